// ==== logic/video_pkg.sv ====
package video_pkg;

	// raster timing, all counts in clk (28 MHz) units or dram cycles
	localparam int dram_cycle_clks   = 4;  // clocks per dram cycle, 7 MHz
	localparam int fetch_dram_cycles = 16; // dram cycles per fetch cycle
	localparam int fetch_words       = 4;  // words per gfx fetch cycle
	localparam int xs_words          = 2;  // words per x-scroll fetch cycle
	localparam int line_slots        = 8;  // fetch cycles per line

	// slot map of one line
	localparam int xs_slot        = 0;
	localparam int gfx_first_slot = 1;
	localparam int gfx_last_slot  = 6; // slot 7 stays idle

	// outstanding requests the arbiter may hold
	localparam int credits_init = 2;

	localparam int vaddr_w = 21; // dram word address

	// register map
	localparam int reg_addr_w = 2;
	localparam logic [reg_addr_w-1:0] reg_ctrl     = 2'd0; // bit0 gfx_en, bit1 xs_en
	localparam logic [reg_addr_w-1:0] reg_gfx_base = 2'd1;
	localparam logic [reg_addr_w-1:0] reg_xs_base  = 2'd2;
	localparam logic [reg_addr_w-1:0] reg_status   = 2'd3; // bit0 underrun, w1c

	// one 16-bit dram word, seen either as two pixel bytes
	// or as an x-scroll entry
	typedef union packed
	{
		struct packed
		{
			logic [7:0] hi; // goes to the lower pic byte
			logic [7:0] lo; // goes to the upper pic byte
		} gfx;
		struct packed
		{
			logic [6:0] rsvd;   // unused upper bits
			logic [8:0] scroll; // scroll offset in pixels
		} xs;
	} video_word_u;

endpackage

// ==== logic/video_ifs.sv ====
`timescale 1ns/1ps

// dram cycle and fetch cycle strobes from the sequencer
interface seq_if;
	logic                                 cend;        // last clk of dram cycle
	logic                                 pre_cend;    // one clk before cend
	logic                                 fetch_start; // cend closing dram cycle 15
	logic [$clog2(video_pkg::line_slots)-1:0] slot;    // slot that begins next
	logic                                 line_start;  // fetch_start into slot 0

	modport src
	(
		output cend, pre_cend, fetch_start, slot, line_start
	);

	modport dst
	(
		input cend, pre_cend, fetch_start, slot, line_start
	);
endinterface

// config from the register block, underrun event back from the fetcher
interface cfg_if;
	logic                         gfx_en;
	logic                         xs_en;
	logic [video_pkg::vaddr_w-1:0] gfx_base;     // first gfx word of a line
	logic [video_pkg::vaddr_w-1:0] xs_base;      // first x-scroll word
	logic                         underrun_set; // one clk pulse per late slot

	modport regs
	(
		output gfx_en, xs_en, gfx_base, xs_base,
		input  underrun_set
	);

	modport fetch
	(
		input  gfx_en, xs_en, gfx_base, xs_base,
		output underrun_set
	);
endinterface

// ==== logic/video_regs.sv ====
`timescale 1ns/1ps

module video_regs
(
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            reg_we,
	input  logic [video_pkg::reg_addr_w-1:0] reg_addr,
	input  logic [video_pkg::vaddr_w-1:0]    reg_wdata,
	output logic [video_pkg::vaddr_w-1:0]    reg_rdata,
	cfg_if.regs                             cfg
);

	logic underrun; // sticky status bit
	logic status_clr;

	// write of 1 to status bit 0
	assign status_clr = reg_we && (reg_addr == video_pkg::reg_status) && reg_wdata[0];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cfg.gfx_en   <= 1'b0;
			cfg.xs_en    <= 1'b0;
			cfg.gfx_base <= '0;
			cfg.xs_base  <= '0;
		end
		else if (reg_we)
		begin
			case (reg_addr)
				video_pkg::reg_ctrl:
				begin
					cfg.gfx_en <= reg_wdata[0];
					cfg.xs_en  <= reg_wdata[1];
				end
				video_pkg::reg_gfx_base: cfg.gfx_base <= reg_wdata;
				video_pkg::reg_xs_base:  cfg.xs_base  <= reg_wdata;
				default: ; // status handled below
			endcase
		end
	end

	// set beats clear when both land on one clk
	always_ff @(posedge clk)
	begin
		if (rst)
			underrun <= 1'b0;
		else if (cfg.underrun_set)
			underrun <= 1'b1;
		else if (status_clr)
			underrun <= 1'b0;
	end

	// readback, plain mux
	always_comb
	begin
		case (reg_addr)
			video_pkg::reg_ctrl:     reg_rdata = {{(video_pkg::vaddr_w-2){1'b0}}, cfg.xs_en, cfg.gfx_en};
			video_pkg::reg_gfx_base: reg_rdata = cfg.gfx_base;
			video_pkg::reg_xs_base:  reg_rdata = cfg.xs_base;
			default:                 reg_rdata = {{(video_pkg::vaddr_w-1){1'b0}}, underrun};
		endcase
	end

	// fetcher only reports late slots of an enabled kind
	a_underrun_needs_en: assert property (@(posedge clk) disable iff (rst)
		cfg.underrun_set |-> (cfg.gfx_en || cfg.xs_en));

endmodule

// ==== logic/video_seq.sv ====
`timescale 1ns/1ps

module video_seq
(
	input  logic clk,
	input  logic rst,
	seq_if.src   seq
);

	localparam int clk_ctr_w = $clog2(video_pkg::dram_cycle_clks);
	localparam int dc_ctr_w  = $clog2(video_pkg::fetch_dram_cycles);
	localparam int slot_w    = $clog2(video_pkg::line_slots);

	logic [clk_ctr_w-1:0] clk_ctr;  // position inside a dram cycle
	logic [dc_ctr_w-1:0]  dc_ctr;   // dram cycle inside a fetch cycle
	logic [slot_w-1:0]    slot_ctr; // slot currently running

	// 28 MHz to 7 MHz, wraps by itself
	always_ff @(posedge clk)
	begin
		if (rst)
			clk_ctr <= '0;
		else
			clk_ctr <= clk_ctr + 1'b1;
	end

	// strobes decoded from the clk counter
	assign seq.pre_cend = (clk_ctr == clk_ctr_w'(video_pkg::dram_cycle_clks - 2));
	assign seq.cend     = (clk_ctr == clk_ctr_w'(video_pkg::dram_cycle_clks - 1));

	// dram cycle counter, steps once per cend
	always_ff @(posedge clk)
	begin
		if (rst)
			dc_ctr <= '0;
		else if (seq.cend)
			dc_ctr <= dc_ctr + 1'b1;
	end

	// last cend of the fetch cycle
	assign seq.fetch_start = seq.cend &&
		(dc_ctr == dc_ctr_w'(video_pkg::fetch_dram_cycles - 1));

	// slot counter
	// starts on the idle slot so the first full fetch cycle is slot 0
	always_ff @(posedge clk)
	begin
		if (rst)
			slot_ctr <= slot_w'(video_pkg::line_slots - 1);
		else if (seq.fetch_start)
			slot_ctr <= slot_ctr + 1'b1;
	end

	assign seq.slot       = slot_ctr + 1'b1; // next slot, wraps 7 -> 0
	assign seq.line_start = seq.fetch_start && (seq.slot == '0);

	// strobe ordering as seen by the fetcher
	a_cend_after_pre: assert property (@(posedge clk) disable iff (rst)
		seq.cend |-> $past(seq.pre_cend));

	// dram cycle count wraps only if fetch_start fell on a cend
	a_fetch_on_cend: assert property (@(posedge clk) disable iff (rst)
		seq.fetch_start |=> (dc_ctr == '0));

endmodule

// ==== logic/video_fetch.sv ====
`timescale 1ns/1ps

module video_fetch
(
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         video_strobe, // data valid from arbiter
	input  logic [15:0]                  video_data,
	input  logic                         credit_ret,   // one credit back
	output logic                         video_req,
	output logic [video_pkg::vaddr_w-1:0] video_addr,
	output logic [63:0]                  pic_bits,     // to renderer
	output logic                         pic_valid,
	output logic [8:0]                   xs0,
	output logic [8:0]                   xs1,
	seq_if.dst                           seq,
	cfg_if.fetch                         cfg
);

	logic [1:0] credits;     // free request slots at the arbiter
	logic [1:0] in_flight;   // requests issued, data not yet back
	logic [1:0] discard_cnt; // stale words still to be dropped
	logic       slot_gfx;    // current slot fetches gfx
	logic       slot_xs;     // current slot fetches x-scroll
	logic [2:0] cur_slot;
	logic [2:0] issue_cnt;   // requests sent this slot
	logic [2:0] fill_cnt;    // words stored this slot, also fill pointer
	logic [2:0] n_words;
	logic [4:0] line_word;   // gfx word offset of the slot within the line
	logic [4:0] gfx_off;
	logic       nxt_gfx;
	logic       nxt_xs;
	logic       stale;
	logic       take;
	logic       pic_pend;    // judged good, pic_bits load next clk
	video_pkg::video_word_u word_in;
	video_pkg::video_word_u wbuf [video_pkg::fetch_words];

	assign word_in = video_data; // decoded per slot kind

	// kind of the slot that starts on this fetch_start
	assign nxt_gfx = cfg.gfx_en && (seq.slot >= video_pkg::gfx_first_slot) &&
		(seq.slot <= video_pkg::gfx_last_slot);
	assign nxt_xs  = cfg.xs_en && (seq.slot == video_pkg::xs_slot);

	assign n_words = slot_xs ? 3'(video_pkg::xs_words) : 3'(video_pkg::fetch_words);

	// one request per dram cycle at most, never on the closing cend
	assign video_req = seq.cend && !seq.fetch_start && (slot_gfx || slot_xs) &&
		(issue_cnt < n_words) && (credits != 2'd0);

	assign gfx_off    = line_word + issue_cnt; // up to 23
	assign video_addr = slot_xs ?
		cfg.xs_base + {{(video_pkg::vaddr_w-3){1'b0}}, issue_cnt} :
		cfg.gfx_base + {{(video_pkg::vaddr_w-5){1'b0}}, gfx_off};

	// late slot, judged with the enables still on
	assign cfg.underrun_set = seq.fetch_start &&
		((slot_gfx && cfg.gfx_en && (fill_cnt < 3'(video_pkg::fetch_words))) ||
		 (slot_xs && cfg.xs_en && (fill_cnt < 3'(video_pkg::xs_words))));

	// words of a finished slot are dropped, credits still come back
	assign stale = video_strobe && (seq.fetch_start || (discard_cnt != 2'd0));
	assign take  = video_strobe && !stale;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			credits     <= 2'(video_pkg::credits_init);
			in_flight   <= 2'd0;
			discard_cnt <= 2'd0;
		end
		else
		begin
			case ({video_req, credit_ret})
				2'b10: credits <= credits - 2'd1;
				2'b01: credits <= credits + 2'd1;
				default: ;
			endcase
			case ({video_req, video_strobe})
				2'b10: in_flight <= in_flight + 2'd1;
				2'b01: in_flight <= in_flight - 2'd1;
				default: ;
			endcase
			if (seq.fetch_start) // all outstanding words go stale
				discard_cnt <= video_strobe ? in_flight - 2'd1 : in_flight;
			else if (stale)
				discard_cnt <= discard_cnt - 2'd1;
		end
	end

	// slot bookkeeping, like fetch_ptr_clr
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			slot_gfx  <= 1'b0;
			slot_xs   <= 1'b0;
			cur_slot  <= 3'(video_pkg::line_slots - 1);
			issue_cnt <= 3'd0;
			fill_cnt  <= 3'd0;
			line_word <= 5'd0;
			pic_pend  <= 1'b0;
		end
		else
		begin
			pic_pend <= seq.fetch_start && slot_gfx && cfg.gfx_en &&
				(fill_cnt == 3'(video_pkg::fetch_words));
			if (seq.fetch_start)
			begin
				slot_gfx  <= nxt_gfx;
				slot_xs   <= nxt_xs;
				cur_slot  <= seq.slot;
				issue_cnt <= 3'd0;
				fill_cnt  <= 3'd0;
				if (seq.line_start)
					line_word <= 5'd0;
				else if ((cur_slot >= video_pkg::gfx_first_slot) &&
					(cur_slot <= video_pkg::gfx_last_slot))
					line_word <= line_word + 5'(video_pkg::fetch_words); // skip dropped too
			end
			else
			begin
				if (video_req)
					issue_cnt <= issue_cnt + 3'd1;
				if (take && (fill_cnt < 3'(video_pkg::fetch_words)))
					fill_cnt <= fill_cnt + 3'd1;
			end
		end
	end

	// word buffer
	always_ff @(posedge clk)
	begin
		if (take && (fill_cnt < 3'(video_pkg::fetch_words)))
			wbuf[fill_cnt[1:0]] <= word_in;
	end

	// renderer side, 2 clks after fetch_start
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pic_valid <= 1'b0;
			pic_bits  <= '0;
			xs0       <= 9'd0;
			xs1       <= 9'd0;
		end
		else
		begin
			pic_valid <= pic_pend;
			if (pic_pend)
			begin
				for (int i = 0; i < video_pkg::fetch_words; i++)
				begin
					pic_bits[16*i +: 8]   <= wbuf[i].gfx.hi; // hi byte shown first
					pic_bits[16*i+8 +: 8] <= wbuf[i].gfx.lo;
				end
			end
			if (take && slot_xs && (fill_cnt == 3'd0))
				xs0 <= word_in.xs.scroll;
			if (take && slot_xs && (fill_cnt == 3'd1))
				xs1 <= word_in.xs.scroll;
		end
	end

	// credit count and in-flight count must agree, arbiter never overfilled
	a_req_has_credit: assert property (@(posedge clk) disable iff (rst)
		video_req |-> (in_flight < 2'(video_pkg::credits_init)));

	// arbiter must not return more than it was given
	a_credit_limit: assert property (@(posedge clk) disable iff (rst)
		credits <= 2'(video_pkg::credits_init));

endmodule

// ==== logic/video_top.sv ====
`timescale 1ns/1ps

module video_top
(
	input  logic                            clk,
	input  logic                            rst,

	// register bus
	input  logic                            reg_we,
	input  logic [video_pkg::reg_addr_w-1:0] reg_addr,
	input  logic [video_pkg::vaddr_w-1:0]    reg_wdata,
	output logic [video_pkg::vaddr_w-1:0]    reg_rdata,

	// dram arbiter side
	output logic                            video_req,
	output logic [video_pkg::vaddr_w-1:0]    video_addr,
	input  logic                            video_strobe,
	input  logic [15:0]                     video_data,
	input  logic                            credit_ret,

	// renderer side
	output logic [63:0]                     pic_bits,
	output logic                            pic_valid,
	output logic [8:0]                      xs0,
	output logic [8:0]                      xs1
);

	seq_if seq_bus(); // sequencer strobes
	cfg_if cfg_bus(); // mode bits, bases, underrun event

	video_regs regs_i
	(
		.clk       (clk),
		.rst       (rst),
		.reg_we    (reg_we),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.cfg       (cfg_bus.regs)
	);

	video_seq seq_i
	(
		.clk (clk),
		.rst (rst),
		.seq (seq_bus.src)
	);

	video_fetch fetch_i
	(
		.clk          (clk),
		.rst          (rst),
		.video_strobe (video_strobe),
		.video_data   (video_data),
		.credit_ret   (credit_ret),
		.video_req    (video_req),
		.video_addr   (video_addr),
		.pic_bits     (pic_bits),
		.pic_valid    (pic_valid),
		.xs0          (xs0),
		.xs1          (xs1),
		.seq          (seq_bus.dst),
		.cfg          (cfg_bus.fetch)
	);

endmodule

// ==== sim/video_tb.sv ====
`timescale 1ns/1ps

module video_tb;

	localparam int slot_clks  = video_pkg::fetch_dram_cycles * video_pkg::dram_cycle_clks; // 64
	localparam int line_clks  = video_pkg::line_slots * slot_clks; // 512
	localparam int n_rows     = 7;
	localparam int stall_clks = 80; // longer than a slot, forces underrun

	// one row of the config table
	typedef struct packed
	{
		logic [1:0]                    ctrl; // bit0 gfx_en, bit1 xs_en
		logic [video_pkg::vaddr_w-1:0] gfx_base;
		logic [video_pkg::vaddr_w-1:0] xs_base;
		int                            lines; // lines to run
		logic                          stall; // dram model holds data past slot end
		logic                          exp_under; // status bit after the row
	} row_t;

	logic                            clk = 1'b0;
	logic                            rst;
	logic                            reg_we;
	logic [video_pkg::reg_addr_w-1:0] reg_addr;
	logic [video_pkg::vaddr_w-1:0]    reg_wdata;
	logic [video_pkg::vaddr_w-1:0]    reg_rdata;
	logic                            video_req;
	logic [video_pkg::vaddr_w-1:0]    video_addr;
	logic                            video_strobe;
	logic [15:0]                     video_data;
	logic                            credit_ret;
	logic [63:0]                     pic_bits;
	logic                            pic_valid;
	logic [8:0]                      xs0;
	logic [8:0]                      xs1;

	row_t rows [n_rows];
	int   cyc = 0;         // clk count, 0 is the first cycle out of reset
	int   limit = 0;       // timeout in cycles
	int   err_main = 0;    // stimulus process checks
	int   err_mon = 0;     // monitor checks
	int   pic_cnt = 0;
	int   req_idx = 0;     // requests seen in the current slot
	int   outstanding = 0; // requests without data yet
	logic stall_mode = 1'b0;
	logic [1:0] exp_ctrl = 2'b00;
	logic [video_pkg::vaddr_w-1:0] exp_gfx = '0;
	logic [video_pkg::vaddr_w-1:0] exp_xs = '0;
	logic [video_pkg::vaddr_w-1:0] addr_q [$]; // dram model request queue
	int   due_q [$];

	video_top dut_i
	(
		.clk          (clk),
		.rst          (rst),
		.reg_we       (reg_we),
		.reg_addr     (reg_addr),
		.reg_wdata    (reg_wdata),
		.reg_rdata    (reg_rdata),
		.video_req    (video_req),
		.video_addr   (video_addr),
		.video_strobe (video_strobe),
		.video_data   (video_data),
		.credit_ret   (credit_ret),
		.pic_bits     (pic_bits),
		.pic_valid    (pic_valid),
		.xs0          (xs0),
		.xs1          (xs1)
	);

	always #2 clk = ~clk; // 4 ns period

	always @(posedge clk)
	begin
		if (rst)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	// dram content, a simple hash of the address
	function automatic logic [15:0] model_word(input logic [video_pkg::vaddr_w-1:0] a);
		return a[15:0] ^ 16'h5a3c;
	endfunction

	// four words of one gfx slot, high byte first in each 16 bit lane
	function automatic logic [63:0] expect_pic(input logic [video_pkg::vaddr_w-1:0] base,
		input int s);
		logic [63:0] p;
		logic [15:0] w;
		p = '0;
		for (int k = 0; k < 4; k++)
		begin
			w = model_word(base + video_pkg::vaddr_w'(4 * (s - 1) + k));
			p[16*k +: 8]   = w[15:8];
			p[16*k+8 +: 8] = w[7:0];
		end
		return p;
	endfunction

	task automatic step();
		@(posedge clk);
		#0.5;
	endtask

	task automatic wait_until(input int c);
		while (cyc < c)
			step();
	endtask

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp)
		else
		begin
			err_main++;
			$display("ERR %s got %h exp %h", name, got, exp);
		end
	endtask

	task automatic reg_write(input logic [1:0] a, input logic [video_pkg::vaddr_w-1:0] d);
		reg_we    = 1'b1;
		reg_addr  = a;
		reg_wdata = d;
		step();
		reg_we = 1'b0;
	endtask

	// rdata is combinational, read mid cycle
	task automatic reg_check(input logic [1:0] a, input logic [video_pkg::vaddr_w-1:0] exp,
		input string name);
		reg_addr = a;
		@(negedge clk);
		check_val(name, 64'(reg_rdata), 64'(exp));
		step();
	endtask

	// dram model, in order returns with one credit per strobe
	initial
	begin
		int seed_ret;
		int unused;
		logic [video_pkg::vaddr_w-1:0] a;
		seed_ret     = $urandom(32'h8cf17d34);
		video_strobe = 1'b0;
		video_data   = 16'h0000;
		credit_ret   = 1'b0;
		forever
		begin
			@(negedge clk);
			if (video_req)
			begin
				addr_q.push_back(video_addr);
				if (stall_mode)
					due_q.push_back(cyc + stall_clks);
				else
					due_q.push_back(cyc + 1 + int'($urandom % 6)); // 1 to 6 cycles
			end
			step();
			if ((due_q.size() > 0) && (due_q[0] <= cyc))
			begin
				a            = addr_q.pop_front();
				unused       = due_q.pop_front();
				video_strobe = 1'b1;
				video_data   = model_word(a);
				credit_ret   = 1'b1;
			end
			else
			begin
				video_strobe = 1'b0;
				credit_ret   = 1'b0;
			end
		end
	end

	// request order, credit count and pic_bits, sampled mid cycle
	always @(negedge clk)
	begin
		int s;
		int n_max;
		logic en;
		logic [video_pkg::vaddr_w-1:0] exp_a;
		if (cyc % slot_clks == 0)
			req_idx = 0; // slot boundary
		if (video_req)
		begin
			s = (cyc / slot_clks + 7) % 8; // slot running in this cycle
			if (s == video_pkg::xs_slot)
			begin
				exp_a = exp_xs + video_pkg::vaddr_w'(req_idx);
				n_max = video_pkg::xs_words;
				en    = exp_ctrl[1];
			end
			else if (s <= video_pkg::gfx_last_slot)
			begin
				exp_a = exp_gfx + video_pkg::vaddr_w'(4 * (s - 1) + req_idx);
				n_max = video_pkg::fetch_words;
				en    = exp_ctrl[0];
			end
			else
			begin
				exp_a = '0;
				n_max = 0; // idle slot
				en    = 1'b0;
			end
			assert (en && (req_idx < n_max) && (cyc % 4 == 3))
			else
			begin
				err_mon++;
				$display("request outside an enabled slot or off a cend at cycle %0d", cyc);
			end
			assert (video_addr == exp_a)
			else
			begin
				err_mon++;
				$display("ERR video_addr got %h exp %h", video_addr, exp_a);
			end
			req_idx++;
		end
		outstanding = outstanding + int'(video_req) - int'(video_strobe);
		assert (outstanding <= video_pkg::credits_init)
		else
		begin
			err_mon++;
			$display("more than %0d requests outstanding at cycle %0d",
				video_pkg::credits_init, cyc);
		end
		if (pic_valid)
		begin
			s = ((cyc - 1) / slot_clks + 6) % 8; // slot that just closed
			assert ((cyc % slot_clks == 1) && (s >= 1) && (s <= 6))
			else
			begin
				err_mon++;
				$display("pic_valid out of step with the slot timing at cycle %0d", cyc);
			end
			assert (pic_bits == expect_pic(exp_gfx, s))
			else
			begin
				err_mon++;
				$display("ERR pic_bits got %h exp %h", pic_bits, expect_pic(exp_gfx, s));
			end
			pic_cnt++;
		end
	end

	initial
	begin
		wait (limit > 0);
		while (cyc <= limit)
			@(posedge clk);
		$display("timeout, run still going after %0d cycles", cyc);
		$display("Test FAILED");
		$finish;
	end

	initial
	begin
		int total_lines;
		int row_start;
		int exp_pics;
		int pics0;
		// ctrl, gfx_base, xs_base, lines, stall, underrun
		rows[0] = '{2'b01, 21'h01000, 21'h00200, 2, 1'b0, 1'b0};
		rows[1] = '{2'b10, 21'h02340, 21'h1f0a7, 2, 1'b0, 1'b0};
		rows[2] = '{2'b11, 21'h1fff0, 21'h15555, 3, 1'b0, 1'b0}; // low 16 bits wrap
		rows[3] = '{2'b01, 21'h00800, 21'h00100, 1, 1'b1, 1'b1};
		rows[4] = '{2'b10, 21'h00900, 21'h00310, 1, 1'b1, 1'b1};
		rows[5] = '{2'b11, 21'h0a000, 21'h0b000, 2, 1'b0, 1'b0};
		rows[6] = '{2'b00, 21'h0c000, 21'h0d000, 1, 1'b0, 1'b0}; // all off
		total_lines = 0;
		foreach (rows[i])
			total_lines += rows[i].lines + 1; // one flush line per row
		limit     = total_lines * line_clks + 2000;
		rst       = 1'b1;
		reg_we    = 1'b0;
		reg_addr  = video_pkg::reg_status;
		reg_wdata = '0;
		repeat (3) @(posedge clk);
		#0.5;
		rst = 1'b0;

		@(negedge clk);
		check_val("video_req", 64'(video_req), 64'd0);
		check_val("pic_valid", 64'(pic_valid), 64'd0);
		check_val("pic_bits", pic_bits, 64'd0);
		check_val("xs0", 64'(xs0), 64'd0);
		check_val("xs1", 64'(xs1), 64'd0);
		check_val("reg_rdata status", 64'(reg_rdata), 64'd0);
		step();

		for (int r = 0; r < n_rows; r++)
		begin
			// writes land in the idle slot 7
			stall_mode = rows[r].stall;
			exp_gfx    = rows[r].gfx_base;
			exp_xs     = rows[r].xs_base;
			exp_ctrl   = rows[r].ctrl;
			reg_write(video_pkg::reg_gfx_base, rows[r].gfx_base);
			reg_write(video_pkg::reg_xs_base, rows[r].xs_base);
			reg_write(video_pkg::reg_ctrl, video_pkg::vaddr_w'(rows[r].ctrl));
			reg_check(video_pkg::reg_ctrl, video_pkg::vaddr_w'(rows[r].ctrl), "reg_rdata ctrl");
			reg_check(video_pkg::reg_gfx_base, rows[r].gfx_base, "reg_rdata gfx_base");
			reg_check(video_pkg::reg_xs_base, rows[r].xs_base, "reg_rdata xs_base");
			row_start = cyc - cyc % line_clks;
			pics0     = pic_cnt;
			for (int l = 1; l <= rows[r].lines; l++)
			begin
				wait_until(row_start + l * line_clks);
				if (rows[r].ctrl[1] && !rows[r].stall)
				begin
					check_val("xs0", 64'(xs0), 64'(model_word(rows[r].xs_base) & 16'h01ff));
					check_val("xs1", 64'(xs1),
						64'(model_word(rows[r].xs_base + 1'b1) & 16'h01ff));
				end
			end
			reg_write(video_pkg::reg_ctrl, '0);
			exp_ctrl = 2'b00;
			wait_until(row_start + (rows[r].lines + 1) * line_clks); // stale data drains
			exp_pics = (rows[r].ctrl[0] && !rows[r].stall) ? 6 * rows[r].lines : 0;
			check_val("pic_valid count", 64'(pic_cnt - pics0), 64'(exp_pics));
			reg_check(video_pkg::reg_status, video_pkg::vaddr_w'(rows[r].exp_under),
				"reg_rdata underrun");
			reg_write(video_pkg::reg_status, video_pkg::vaddr_w'(1));
			reg_check(video_pkg::reg_status, '0, "reg_rdata underrun cleared");
		end

		$display("errors: checks %0d, monitor %0d", err_main, err_mon);
		if (err_main + err_mon == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
logic/video_pkg.sv
logic/video_ifs.sv
logic/video_regs.sv
logic/video_seq.sv
logic/video_fetch.sv
logic/video_top.sv
sim/video_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the video fetch testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f files.f \
	--top-module video_tb \
	-Mdir obj_dir \
	-o video_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/video_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the testbench prints its fail message on any error or timeout
if grep -q "Test FAILED" "$log"; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation passed"
exit 0
